// ==== Bender.yml ====
package:
  name: erx_remap

sources:
  - erx_pkg.sv
  - erx_remap_cfg.sv
  - erx_remap_decode.sv
  - erx_remap_execute.sv
  - erx_remap_result.sv
  - erx_remap_top.sv
  - target: simulation
    files:
      - tb_erx_remap.sv

// ==== erx_pkg.sv ====
package erx_pkg;

   // mesh packet layout
   localparam int pkt_w    = 104;   // one mesh word
   localparam int addr_w   = 32;
   localparam int addr_lsb = 8;     // destination address field
   localparam int addr_msb = 39;
   localparam int wr_bit   = 1;     // write flag in control byte

   // static remap covers the top of the address
   localparam int sel_w = 12;       // address bits 31..20

   // chip ID of this link
   localparam logic [11:0] elink_id = 12'h808;

   // column part of the ID, start of the local window
   localparam logic [5:0] col_id = elink_id[5:0];

   // shift for the dynamic compression term
   localparam int col_shift = $clog2(col_id);

   // remap rule, encoding 3 is handled as dynamic
   typedef enum logic [1:0] {
      remap_none    = 2'd0,
      remap_static  = 2'd1,
      remap_dynamic = 2'd2
   } remap_mode_e;

   // configuration register map
   typedef enum logic [1:0] {
      cfg_mode    = 2'd0,
      cfg_sel     = 2'd1,
      cfg_pattern = 2'd2,
      cfg_base    = 2'd3
   } cfg_addr_e;

endpackage

// ==== erx_remap_cfg.sv ====
`timescale 1ns/100ps

module erx_remap_cfg
   import erx_pkg::*;
(
   input  logic               clk,
   input  logic               reset,

   // register write port
   input  logic               cfg_write,
   input  cfg_addr_e          cfg_addr,
   input  logic [31:0]        cfg_wdata,

   // remap configuration
   output remap_mode_e        remap_mode,
   output logic [sel_w-1:0]   remap_sel,
   output logic [sel_w-1:0]   remap_pattern,
   output logic [addr_w-1:0]  remap_base
);

   // one register per strobe, all cleared on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         remap_mode    <= remap_none;   // pass-through after reset
         remap_sel     <= '0;
         remap_pattern <= '0;
         remap_base    <= '0;
      end else if (cfg_write) begin
         case (cfg_addr)
            cfg_mode: begin
               // code 3 is kept as written
               remap_mode <= remap_mode_e'(cfg_wdata[1:0]);
            end
            cfg_sel: begin
               remap_sel <= cfg_wdata[sel_w-1:0];      // low bits only
            end
            cfg_pattern: begin
               remap_pattern <= cfg_wdata[sel_w-1:0];
            end
            cfg_base: begin
               remap_base <= cfg_wdata[addr_w-1:0];
            end
            default: begin
               remap_base <= remap_base;   // unknown address, hold
            end
         endcase
      end
   end

   // a write with an unknown address would leave the register choice undefined
   assert property (
      @(posedge clk) disable iff (reset)
      cfg_write |-> !$isunknown(cfg_addr)
   ) else $error("cfg_addr unknown during cfg_write");

endmodule

// ==== erx_remap_decode.sv ====
`timescale 1ns/100ps

module erx_remap_decode
   import erx_pkg::*;
(
   // packet offered by the arbiter
   input  logic [pkt_w-1:0]   packet_in,

   // back-pressure per direction
   input  logic               rd_wait,
   input  logic               wr_wait,

   // decoded fields
   output logic [addr_w-1:0]  addr_in,
   output logic               advance
);

   logic write_in;
   logic read_in;

   // destination address field
   assign addr_in = packet_in[addr_msb:addr_lsb];

   // direction from the control byte
   assign write_in = packet_in[wr_bit];
   assign read_in  = ~packet_in[wr_bit];   // no other packet types here

   // only the wait of this packet's own direction matters,
   // so a blocked read never holds back a write and the
   // other way round
   // advance is formed even when access_in is low, the
   // output register then just loads the idle packet
   always_comb begin
      advance = 1'b0;
      if (write_in) begin
         advance = ~wr_wait;
      end
      if (read_in) begin
         advance = ~rd_wait;
      end
   end

endmodule

// ==== erx_remap_execute.sv ====
`timescale 1ns/100ps

module erx_remap_execute
   import erx_pkg::*;
(
   input  logic               clk,
   input  logic               reset,

   // address from decode
   input  logic [addr_w-1:0]  addr_in,

   // configuration
   input  remap_mode_e        remap_mode,
   input  logic [sel_w-1:0]   remap_sel,
   input  logic [sel_w-1:0]   remap_pattern,
   input  logic [addr_w-1:0]  remap_base,

   // rewritten address to the output register
   output logic [addr_w-1:0]  remap_addr
);

   logic [addr_w-1:0] static_addr;
   logic [addr_w-1:0] dynamic_addr;
   logic [addr_w-1:0] col_start;   // first address of this link's window
   logic [addr_w-1:0] col_adj;     // compression term

   // static rule
   // pattern bits where selected, address bits elsewhere
   assign static_addr[addr_w-1:addr_w-sel_w] =
      (remap_sel & remap_pattern) |
      (~remap_sel & addr_in[addr_w-1:addr_w-sel_w]);
   assign static_addr[addr_w-sel_w-1:0] = addr_in[addr_w-sel_w-1:0];

   // dynamic rule
   // move the window to zero, add the base, then squeeze out the
   // gap left by the row bits
   assign col_start = {{(sel_w-6){1'b0}}, col_id, {(addr_w-sel_w){1'b0}}};
   assign col_adj   = addr_w'(addr_in[addr_w-1:addr_w-6]) << col_shift;

   assign dynamic_addr = addr_in - col_start + remap_base - col_adj;   // mod 2^32

   // rule select
   always_comb begin
      case (remap_mode)
         remap_none: begin
            remap_addr = addr_in;
         end
         remap_static: begin
            remap_addr = static_addr;
         end
         default: begin
            remap_addr = dynamic_addr;   // 2 and 3
         end
      endcase
   end

   // pass-through mode leaves the address alone
   assert property (
      @(posedge clk) disable iff (reset)
      (remap_mode == remap_none) |-> (remap_addr == addr_in)
   ) else $error("remap_addr differs from addr_in in remap_none");

endmodule

// ==== erx_remap_result.sv ====
`timescale 1ns/100ps

module erx_remap_result
   import erx_pkg::*;
(
   input  logic               clk,
   input  logic               reset,

   input  logic               advance,      // from decode
   input  logic               access_in,
   input  logic [pkt_w-1:0]   packet_in,
   input  logic [addr_w-1:0]  remap_addr,   // from execute

   // toward the on-chip mesh
   output logic               access_out,
   output logic [pkt_w-1:0]   packet_out
);

   logic [pkt_w-1:0] packet_new;

   // original packet with the address field swapped
   assign packet_new = {packet_in[pkt_w-1:addr_msb+1],
                        remap_addr,
                        packet_in[addr_lsb-1:0]};

   // access strobe, held while the direction is blocked
   always_ff @(posedge clk) begin
      if (reset) begin
         access_out <= 1'b0;
      end else if (advance) begin
         access_out <= access_in;
      end
   end

   // packet payload
   always_ff @(posedge clk) begin
      if (advance) begin
         packet_out <= packet_new;
      end
   end

   // under wait the outputs freeze, nothing is captured or dropped
   assert property (
      @(posedge clk) disable iff (reset)
      !advance |=> ($stable(access_out) && $stable(packet_out))
   ) else $error("outputs changed after a cycle with advance low");

endmodule

// ==== erx_remap_top.sv ====
`timescale 1ns/100ps

module erx_remap_top
   import erx_pkg::*;
(
   input  logic               clk,
   input  logic               reset,

   // from the link arbiter
   input  logic               access_in,
   input  logic [pkt_w-1:0]   packet_in,

   // downstream back-pressure
   input  logic               rd_wait,
   input  logic               wr_wait,

   // configuration write port
   input  logic               cfg_write,
   input  cfg_addr_e          cfg_addr,
   input  logic [31:0]        cfg_wdata,

   // to the on-chip mesh
   output logic               access_out,
   output logic [pkt_w-1:0]   packet_out
);

   remap_mode_e        remap_mode;
   logic [sel_w-1:0]   remap_sel;
   logic [sel_w-1:0]   remap_pattern;
   logic [addr_w-1:0]  remap_base;
   logic [addr_w-1:0]  addr_in;
   logic [addr_w-1:0]  remap_addr;
   logic               advance;

   erx_remap_cfg i_cfg (
      .clk           (clk),
      .reset         (reset),
      .cfg_write     (cfg_write),
      .cfg_addr      (cfg_addr),
      .cfg_wdata     (cfg_wdata),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base)
   );

   erx_remap_decode i_decode (
      .packet_in (packet_in),
      .rd_wait   (rd_wait),
      .wr_wait   (wr_wait),
      .addr_in   (addr_in),
      .advance   (advance)
   );

   erx_remap_execute i_execute (
      .clk           (clk),
      .reset         (reset),
      .addr_in       (addr_in),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base),
      .remap_addr    (remap_addr)
   );

   erx_remap_result i_result (
      .clk        (clk),
      .reset      (reset),
      .advance    (advance),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .remap_addr (remap_addr),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

// ==== tb_erx_remap.sv ====
`timescale 1ns/100ps

module tb_erx_remap
   import erx_pkg::*;
();

   // test lengths in cycles
   localparam int n_reset   = 5;
   localparam int n_none    = 150;
   localparam int n_cfg     = 8;     // configurations per remap mode
   localparam int n_per     = 30;
   localparam int n_bp_blk  = 6;
   localparam int n_bp      = 60;
   localparam int total_cycles = n_reset + 2 + n_none + 1 + n_cfg * (2 + n_per) + 1
                                 + n_cfg * (1 + n_per) + n_bp_blk * (1 + n_bp) + 4;
   localparam int margin_cycles = 200;

   logic               clk;
   logic               reset;
   logic               access_in;
   logic [pkt_w-1:0]   packet_in;
   logic               rd_wait;
   logic               wr_wait;
   logic               cfg_write;
   cfg_addr_e          cfg_addr;
   logic [31:0]        cfg_wdata;
   logic               access_out;
   logic [pkt_w-1:0]   packet_out;

   // reference model state
   logic [1:0]         m_mode;
   logic [sel_w-1:0]   m_sel;
   logic [sel_w-1:0]   m_pat;
   logic [addr_w-1:0]  m_base;
   logic               adv_ref;
   logic               exp_access;
   logic [pkt_w-1:0]   exp_packet;
   logic               pkt_valid = 1'b0;
   logic               prev_access;
   logic [pkt_w-1:0]   prev_packet;
   logic               prev_hold = 1'b0;
   logic               prev_cross = 1'b0;
   logic               prev_in_access;

   int reset_errors  = 0;
   int access_errors = 0;
   int packet_errors = 0;
   int hold_errors   = 0;
   int total_errors;

   erx_remap_top i_dut (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .rd_wait    (rd_wait),
      .wr_wait    (wr_wait),
      .cfg_write  (cfg_write),
      .cfg_addr   (cfg_addr),
      .cfg_wdata  (cfg_wdata),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // expected address from the remap rules
   function automatic logic [addr_w-1:0] ref_remap(input logic [addr_w-1:0] addr,
                                                   input logic [1:0] mode,
                                                   input logic [sel_w-1:0] sel,
                                                   input logic [sel_w-1:0] pat,
                                                   input logic [addr_w-1:0] base);
      logic [addr_w-1:0] res;
      logic [addr_w-1:0] window;
      logic [addr_w-1:0] squeeze;
      window  = addr_w'(col_id) << 20;
      squeeze = addr_w'(addr[31:26]) << col_shift;
      case (mode)
         2'd0: res = addr;
         2'd1: res = {(sel & pat) | (~sel & addr[31:20]), addr[19:0]};
         default: res = addr - window + base - squeeze;   // 2 and 3
      endcase
      return res;
   endfunction

   // own direction decides, opposite wait is ignored
   assign adv_ref = packet_in[wr_bit] ? !wr_wait : !rd_wait;

   always @(posedge clk) begin
      prev_access    <= access_out;
      prev_packet    <= packet_out;
      prev_in_access <= access_in;
      prev_hold      <= !reset && !adv_ref && pkt_valid;
      prev_cross     <= !reset && adv_ref && (packet_in[wr_bit] ? rd_wait : wr_wait);
      if (reset) begin
         m_mode     <= 2'd0;
         m_sel      <= '0;
         m_pat      <= '0;
         m_base     <= '0;
         exp_access <= 1'b0;
      end else begin
         if (cfg_write) begin
            case (cfg_addr)
               cfg_mode:    m_mode <= cfg_wdata[1:0];
               cfg_sel:     m_sel  <= cfg_wdata[sel_w-1:0];
               cfg_pattern: m_pat  <= cfg_wdata[sel_w-1:0];
               default:     m_base <= cfg_wdata;
            endcase
         end
         if (adv_ref) exp_access <= access_in;
      end
      // config in use this cycle, a write only counts from the next one
      if (adv_ref) begin
         exp_packet <= {packet_in[pkt_w-1:addr_msb+1],
                        ref_remap(packet_in[addr_msb:addr_lsb], m_mode, m_sel, m_pat, m_base),
                        packet_in[addr_lsb-1:0]};
         if (!reset) pkt_valid <= 1'b1;
      end
   end

   a_reset: assert property (@(posedge clk) reset |=> !access_out)
      else begin
         reset_errors++;
         $display("Fail %0t access_out expected 0 got %b", $time, $sampled(access_out));
      end

   a_access: assert property (@(posedge clk) disable iff (reset) access_out == exp_access)
      else begin
         access_errors++;
         $display("Fail %0t access_out expected %b got %b", $time,
                  $sampled(exp_access), $sampled(access_out));
      end

   a_addr: assert property (@(posedge clk) disable iff (reset)
      pkt_valid |-> packet_out[addr_msb:addr_lsb] == exp_packet[addr_msb:addr_lsb])
      else begin
         packet_errors++;
         $display("Fail %0t packet_out[39:8] expected %h got %h", $time,
                  $sampled(exp_packet[addr_msb:addr_lsb]),
                  $sampled(packet_out[addr_msb:addr_lsb]));
      end

   // upper fields and control byte pass untouched
   a_fields: assert property (@(posedge clk) disable iff (reset)
      pkt_valid |-> (packet_out[pkt_w-1:addr_msb+1] == exp_packet[pkt_w-1:addr_msb+1] &&
                     packet_out[addr_lsb-1:0] == exp_packet[addr_lsb-1:0]))
      else begin
         packet_errors++;
         $display("Fail %0t packet_out other fields expected %h got %h", $time,
                  $sampled(exp_packet), $sampled(packet_out));
      end

   a_hold: assert property (@(posedge clk) disable iff (reset)
      prev_hold |-> (access_out == prev_access && packet_out == prev_packet))
      else begin
         hold_errors++;
         $display("Fail %0t access_out/packet_out expected %b/%h got %b/%h", $time,
                  $sampled(prev_access), $sampled(prev_packet),
                  $sampled(access_out), $sampled(packet_out));
      end

   // opposite wait high must not block
   a_cross: assert property (@(posedge clk) disable iff (reset)
      prev_cross |-> access_out == prev_in_access)
      else begin
         hold_errors++;
         $display("Fail %0t access_out expected %b got %b", $time,
                  $sampled(prev_in_access), $sampled(access_out));
      end

   // new packet only once the old one went through
   task automatic random_inputs(input int wait_pct);
      logic [127:0] r;
      r = {$urandom, $urandom, $urandom, $urandom};
      if (adv_ref) begin
         access_in = ($urandom % 4) != 0;
         packet_in = r[pkt_w-1:0];
      end
      rd_wait = ($urandom % 100) < wait_pct;
      wr_wait = ($urandom % 100) < wait_pct;
   endtask

   task automatic run_cycles(input int n, input int wait_pct);
      repeat (n) begin
         @(negedge clk);
         cfg_write = 1'b0;
         random_inputs(wait_pct);
      end
   endtask

   task automatic write_cfg(input cfg_addr_e a, input logic [31:0] d);
      @(negedge clk);
      random_inputs(10);
      cfg_write = 1'b1;
      cfg_addr  = a;
      cfg_wdata = d;
   endtask

   initial begin
      #(total_cycles * 10 + margin_cycles * 10);
      $display("watchdog: run timed out before the tests completed");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      int i;
      void'($urandom(32'hd4e5934a));
      reset     = 1'b1;
      access_in = 1'b0;
      packet_in = '0;
      rd_wait   = 1'b0;
      wr_wait   = 1'b0;
      cfg_write = 1'b0;
      cfg_addr  = cfg_mode;
      cfg_wdata = '0;
      repeat (n_reset) @(negedge clk);
      reset = 1'b0;
      repeat (2) @(negedge clk);   // idle, access_out stays low

      run_cycles(n_none, 10);      // remap_none

      write_cfg(cfg_mode, 32'(remap_static));
      for (i = 0; i < n_cfg; i++) begin
         write_cfg(cfg_sel, $urandom);
         write_cfg(cfg_pattern, $urandom);
         run_cycles(n_per, 10);
      end

      write_cfg(cfg_mode, 32'(remap_dynamic));
      for (i = 0; i < n_cfg; i++) begin
         // second half runs on encoding 3
         if (i == n_cfg / 2) write_cfg(cfg_mode, 32'd3);
         else write_cfg(cfg_base, $urandom);
         run_cycles(n_per, 10);
      end

      // heavy back-pressure with mode changes
      for (i = 0; i < n_bp_blk; i++) begin
         write_cfg(cfg_mode, $urandom % 4);
         run_cycles(n_bp, 50);
      end
      run_cycles(4, 0);

      total_errors = reset_errors + access_errors + packet_errors + hold_errors;
      $display("errors: reset %0d, access %0d, packet %0d, hold %0d, total %0d",
               reset_errors, access_errors, packet_errors, hold_errors, total_errors);
      if (total_errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
erx_pkg.sv
erx_remap_cfg.sv
erx_remap_decode.sv
erx_remap_execute.sv
erx_remap_result.sv
erx_remap_top.sv
tb_erx_remap.sv
